// File: gb_core_params.svh
`ifndef GB_CORE_PARAMS_SVH
`define GB_CORE_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core build parameters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Memory address width, 1 KiB of program and data.
`define GB_ADDR_W 10

// Stack pointer value after reset.
`define GB_SP_RESET 16'hFFFE

// HALT opcode, sits in the middle of the LD r,r' block.
`define GB_OP_HALT 8'h76

`endif

// File: gb_core_pkg.sv
`default_nettype none

package gb_core_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [7:0] byte_t;	// Data byte.
	typedef logic [15:0] addr_t;	// CPU address.
	typedef logic [3:0] flags_t;	// Z N H C.
	typedef logic [2:0] reg_sel_t;	// B C D E H L (HL) A.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath control encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		SRC_NONE,
		SRC_REGA,
		SRC_REGB,
		SRC_MDR,
		SRC_PC_L,
		SRC_PC_H
	} alu_src_t;

	typedef enum logic [2:0] {
		DEST_NONE,
		DEST_REG,
		DEST_MDR,
		DEST_MAR_L,
		DEST_MAR_H,
		DEST_MAR_HL,
		DEST_PC_LATCH
	} alu_dest_t;

	typedef enum logic [2:0] {
		ALU_PASS_A,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC
	} alu_op_t;

	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		READ_IMM1,
		READ_IMM2,
		MEM_RD,
		MEM_WR,
		EXEC,
		WRITEBACK,
		HALTED
	} cpu_state_t;

endpackage

`default_nettype wire

// File: gb_core_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// Control bundle from control path to datapath.
interface ctrl_if;
	import gb_core_pkg::*;

	logic fetch, load_op_code, read_en, write_en, ld_flags;
	alu_src_t alu_src_a, alu_src_b;
	alu_op_t alu_op;
	alu_dest_t alu_dest;
	reg_sel_t reg_sel_a, reg_sel_b;
	flags_t flags;	// Current flags, for JP NZ.
	byte_t ir;

	modport ctrl (output fetch, load_op_code, read_en, write_en, ld_flags,
		alu_src_a, alu_src_b, alu_op, alu_dest, reg_sel_a, reg_sel_b,
		input flags, ir);
	modport dp (input fetch, load_op_code, read_en, write_en, ld_flags,
		alu_src_a, alu_src_b, alu_op, alu_dest, reg_sel_a, reg_sel_b,
		output flags, ir);
endinterface

// CPU memory port, one cycle read latency.
interface mem_if;
	import gb_core_pkg::*;

	addr_t addr;
	byte_t wdata, rdata;
	logic re, we;

	modport cpu (output addr, wdata, re, we, input rdata);
	modport mem (input addr, wdata, re, we, output rdata);
endinterface

`default_nettype wire

// File: register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
	input logic clk,
	input logic rst,
	input gb_core_pkg::reg_sel_t sel_a,
	input gb_core_pkg::reg_sel_t sel_b,
	input gb_core_pkg::reg_sel_t wr_sel,
	input logic wr_en,
	input gb_core_pkg::byte_t wr_data,
	input logic flags_we,
	input gb_core_pkg::flags_t flags_in,
	output gb_core_pkg::byte_t out_a,
	output gb_core_pkg::byte_t out_b,
	output gb_core_pkg::flags_t flags,
	output gb_core_pkg::addr_t hl,
	output logic [63:0] window
);
	import gb_core_pkg::*;

	localparam reg_sel_t IDX_HL_IND = 3'd6;	// Memory operand, no storage.

	byte_t regs [0:7];	// Slot 6 never written.
	flags_t f_q;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 8'h00;
			end
			f_q <= 4'h0;
		end else begin
			if (wr_en && wr_sel != IDX_HL_IND)
				regs[wr_sel] <= wr_data;
			if (flags_we)
				f_q <= flags_in;	// Same cycle as a data write is fine.
		end
	end

	assign out_a = (sel_a == IDX_HL_IND) ? 8'h00 : regs[sel_a];
	assign out_b = (sel_b == IDX_HL_IND) ? 8'h00 : regs[sel_b];
	assign flags = f_q;
	assign hl = {regs[4], regs[5]};

	// Debug view, A in the low byte up to L in the top byte.
	assign window = {regs[5], regs[4], f_q, 4'h0, regs[3],
		regs[2], regs[1], regs[0], regs[7]};

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input gb_core_pkg::byte_t op_a,
	input gb_core_pkg::byte_t op_b,
	input gb_core_pkg::alu_op_t op,
	input gb_core_pkg::flags_t curr_flags,
	output gb_core_pkg::byte_t result,
	output gb_core_pkg::flags_t next_flags
);
	import gb_core_pkg::*;

	logic [8:0] sum, diff;
	logic half_add, half_sub;
	logic z, n, h, c;

	assign sum = {1'b0, op_a} + {1'b0, op_b};
	assign diff = {1'b0, op_a} - {1'b0, op_b};	// Bit 8 is the borrow.
	assign half_add = ({1'b0, op_a[3:0]} + {1'b0, op_b[3:0]}) > 5'h0F;
	assign half_sub = op_a[3:0] < op_b[3:0];

	always_comb begin
		result = op_a;
		n = 1'b0;
		h = curr_flags[1];
		c = curr_flags[0];
		case (op)
			ALU_ADD: begin
				result = sum[7:0];
				h = half_add;
				c = sum[8];
			end
			ALU_SUB: begin
				result = diff[7:0];
				n = 1'b1;
				h = half_sub;
				c = diff[8];
			end
			ALU_AND: begin
				result = op_a & op_b;
				h = 1'b1;
				c = 1'b0;
			end
			ALU_OR: begin
				result = op_a | op_b;
				h = 1'b0;
				c = 1'b0;
			end
			ALU_XOR: begin
				result = op_a ^ op_b;
				h = 1'b0;
				c = 1'b0;
			end
			ALU_INC: begin
				result = op_a + 8'd1;
				h = (op_a[3:0] == 4'hF);	// C left alone.
			end
			default: begin
				n = curr_flags[2];	// Pass keeps all flags.
			end
		endcase
		z = (result == 8'h00);
		if (op == ALU_PASS_A)
			z = curr_flags[3];
	end

	assign next_flags = {z, n, h, c};

endmodule

`default_nettype wire

// File: control_path.sv
`timescale 1ns/100ps
`default_nettype none
`include "gb_core_params.svh"

module control_path (
	input logic clk,
	input logic rst,
	ctrl_if.ctrl ctrl,
	output logic halted
);
	import gb_core_pkg::*;

	localparam reg_sel_t IDX_HL = 3'd6;
	localparam reg_sel_t IDX_A = 3'd7;

	cpu_state_t state, state_next;
	reg_sel_t dst, src;
	logic is_halt, is_ld_imm, is_ld_rr, is_alu, is_inc;
	logic is_ld_a_hl, is_ld_hl_a, is_jp, jp_taken;
	alu_op_t alu_kind;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcode decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign dst = ctrl.ir[5:3];
	assign src = ctrl.ir[2:0];
	assign is_halt = (ctrl.ir == `GB_OP_HALT);
	assign is_ld_imm = (ctrl.ir[7:6] == 2'b00) && (src == 3'd6) && (dst != IDX_HL);
	assign is_inc = (ctrl.ir[7:6] == 2'b00) && (src == 3'd4) && (dst != IDX_HL);
	assign is_ld_rr = (ctrl.ir[7:6] == 2'b01) && (dst != IDX_HL) && (src != IDX_HL);
	assign is_ld_a_hl = (ctrl.ir == 8'h7E);
	assign is_ld_hl_a = (ctrl.ir == 8'h77);
	assign is_jp = (ctrl.ir == 8'hC3) || (ctrl.ir == 8'hC2);
	assign jp_taken = (ctrl.ir == 8'hC3) || !ctrl.flags[3];	// NZ tests Z.

	always_comb begin
		case (dst)
			3'd0: alu_kind = ALU_ADD;
			3'd2: alu_kind = ALU_SUB;
			3'd4: alu_kind = ALU_AND;
			3'd5: alu_kind = ALU_XOR;
			default: alu_kind = ALU_OR;	// Only 6 gets through.
		endcase
	end
	assign is_alu = (ctrl.ir[7:6] == 2'b10) && (src != IDX_HL) &&
		(dst == 3'd0 || dst == 3'd2 || dst == 3'd4 || dst == 3'd5 || dst == 3'd6);

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			state <= FETCH;
		else
			state <= state_next;
	end

	assign halted = (state == HALTED);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencing and control outputs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_next = state;
		ctrl.fetch = 1'b0;
		ctrl.load_op_code = 1'b0;
		ctrl.read_en = 1'b0;
		ctrl.write_en = 1'b0;
		ctrl.ld_flags = 1'b0;
		ctrl.alu_src_a = SRC_NONE;
		ctrl.alu_src_b = SRC_NONE;
		ctrl.alu_op = ALU_PASS_A;
		ctrl.alu_dest = DEST_NONE;
		ctrl.reg_sel_a = IDX_A;
		ctrl.reg_sel_b = src;
		case (state)
			FETCH: begin
				ctrl.fetch = 1'b1;	// Read at PC, PC advances.
				ctrl.read_en = 1'b1;
				state_next = DECODE;
			end
			DECODE: begin
				ctrl.load_op_code = 1'b1;
				state_next = EXEC;
			end
			EXEC: begin
				if (is_halt) begin
					state_next = HALTED;
				end else if (is_ld_a_hl || is_ld_hl_a) begin
					ctrl.alu_dest = DEST_MAR_HL;
					state_next = is_ld_a_hl ? READ_IMM1 : WRITEBACK;
				end else if (is_ld_imm || is_jp) begin
					state_next = READ_IMM1;
				end else if (is_alu || is_inc || is_ld_rr) begin
					ctrl.alu_src_a = is_ld_rr ? SRC_REGB : SRC_REGA;
					ctrl.alu_src_b = SRC_REGB;
					ctrl.reg_sel_a = is_inc ? dst : IDX_A;
					ctrl.alu_op = is_alu ? alu_kind : (is_inc ? ALU_INC : ALU_PASS_A);
					ctrl.alu_dest = DEST_MDR;	// Result parks in MDR.
					ctrl.ld_flags = !is_ld_rr;
					state_next = WRITEBACK;
				end else begin
					state_next = FETCH;	// NOP and unsupported.
				end
			end
			READ_IMM1: begin
				ctrl.read_en = 1'b1;
				ctrl.fetch = !is_ld_a_hl;	// (HL) read uses MAR.
				state_next = is_jp ? READ_IMM2 : MEM_RD;
			end
			READ_IMM2: begin
				ctrl.read_en = 1'b1;
				ctrl.fetch = 1'b1;
				state_next = MEM_RD;
			end
			MEM_RD: begin
				if (is_jp) begin
					ctrl.alu_src_a = SRC_MDR;	// Target low byte.
					ctrl.alu_dest = DEST_MAR_L;
					state_next = MEM_WR;
				end else begin
					state_next = WRITEBACK;
				end
			end
			MEM_WR: begin
				if (is_jp) begin
					ctrl.alu_src_a = SRC_MDR;	// Target high byte.
					ctrl.alu_dest = DEST_MAR_H;
					state_next = WRITEBACK;
				end else begin
					ctrl.write_en = 1'b1;
					state_next = FETCH;
				end
			end
			WRITEBACK: begin
				state_next = FETCH;
				if (is_jp) begin
					ctrl.alu_dest = jp_taken ? DEST_PC_LATCH : DEST_NONE;
				end else if (is_ld_hl_a) begin
					ctrl.alu_src_a = SRC_REGA;
					ctrl.alu_dest = DEST_MDR;
					state_next = MEM_WR;
				end else begin
					ctrl.alu_src_a = SRC_MDR;
					ctrl.reg_sel_a = is_alu ? IDX_A : dst;
					ctrl.alu_dest = DEST_REG;
				end
			end
			default: state_next = HALTED;	// Held until reset.
		endcase
	end

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/100ps
`default_nettype none
`include "gb_core_params.svh"

module datapath (
	input logic clk,
	input logic rst,
	ctrl_if.dp ctrl,
	mem_if.cpu mem,
	output logic [63:0] window
);
	import gb_core_pkg::*;

	addr_t pc, sp, mar, hl;
	byte_t ir, mdr;
	logic rd_q;	// Read data arrives this cycle.
	byte_t out_a, out_b, in_a, in_b, alu_result;
	flags_t flags, alu_flags;
	logic reg_we, mdr_we, mar_l_we, mar_h_we, mar_hl_we, pc_ld;

	assign reg_we = (ctrl.alu_dest == DEST_REG);
	assign mdr_we = (ctrl.alu_dest == DEST_MDR);
	assign mar_l_we = (ctrl.alu_dest == DEST_MAR_L);
	assign mar_h_we = (ctrl.alu_dest == DEST_MAR_H);
	assign mar_hl_we = (ctrl.alu_dest == DEST_MAR_HL);
	assign pc_ld = (ctrl.alu_dest == DEST_PC_LATCH);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= 16'h0000;
			sp <= `GB_SP_RESET;
			mar <= 16'h0000;
			ir <= 8'h00;
			mdr <= 8'h00;
			rd_q <= 1'b0;
		end else begin
			rd_q <= ctrl.read_en;
			if (ctrl.fetch)
				pc <= pc + 16'd1;
			else if (pc_ld)
				pc <= mar;	// Jump target assembled in MAR.
			if (ctrl.fetch)
				mar <= pc;
			else if (mar_hl_we)
				mar <= hl;
			else if (mar_l_we)
				mar[7:0] <= alu_result;
			else if (mar_h_we)
				mar[15:8] <= alu_result;
			if (ctrl.load_op_code)
				ir <= mem.rdata;
			if (rd_q && !ctrl.load_op_code)
				mdr <= mem.rdata;
			else if (mdr_we)
				mdr <= alu_result;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operand select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic byte_t pick(alu_src_t s, byte_t a, byte_t b, byte_t m, addr_t p);
		case (s)
			SRC_REGA: return a;
			SRC_REGB: return b;
			SRC_MDR: return m;
			SRC_PC_L: return p[7:0];
			SRC_PC_H: return p[15:8];
			default: return 8'h00;
		endcase
	endfunction

	assign in_a = pick(ctrl.alu_src_a, out_a, out_b, mdr, pc);
	assign in_b = pick(ctrl.alu_src_b, out_a, out_b, mdr, pc);

	register_file register_file_i (
		.clk(clk),
		.rst(rst),
		.sel_a(ctrl.reg_sel_a),
		.sel_b(ctrl.reg_sel_b),
		.wr_sel(ctrl.reg_sel_a),
		.wr_en(reg_we),
		.wr_data(alu_result),
		.flags_we(ctrl.ld_flags),
		.flags_in(alu_flags),
		.out_a(out_a),
		.out_b(out_b),
		.flags(flags),
		.hl(hl),
		.window(window)
	);

	alu alu_i (
		.op_a(in_a),
		.op_b(in_b),
		.op(ctrl.alu_op),
		.curr_flags(flags),
		.result(alu_result),
		.next_flags(alu_flags)
	);

	assign ctrl.flags = flags;
	assign ctrl.ir = ir;

	// Opcode and immediate reads go out at PC directly.
	assign mem.addr = ctrl.fetch ? pc : mar;
	assign mem.wdata = mdr;
	assign mem.re = ctrl.read_en;
	assign mem.we = ctrl.write_en;

endmodule

`default_nettype wire

// File: sram.sv
`timescale 1ns/100ps
`default_nettype none
`include "gb_core_params.svh"

module sram (
	input logic clk,
	mem_if.mem mem,
	input logic load_we,
	input logic [`GB_ADDR_W-1:0] load_addr,
	input gb_core_pkg::byte_t load_data
);
	import gb_core_pkg::*;

	localparam int DEPTH = 1 << `GB_ADDR_W;

	byte_t ram [0:DEPTH-1];
	logic [`GB_ADDR_W-1:0] cpu_addr;

	assign cpu_addr = mem.addr[`GB_ADDR_W-1:0];	// Wraps modulo size.

	always_ff @(posedge clk) begin
		if (load_we)
			ram[load_addr] <= load_data;	// Loader beats the CPU.
		else if (mem.we)
			ram[cpu_addr] <= mem.wdata;
		if (mem.re)
			mem.rdata <= ram[cpu_addr];
	end

endmodule

`default_nettype wire

// File: gb_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "gb_core_params.svh"

module gb_core (
	input logic clk,
	input logic rst,
	input logic load_we,
	input logic [`GB_ADDR_W-1:0] load_addr,
	input gb_core_pkg::byte_t load_data,
	output logic halted,
	output gb_core_pkg::byte_t reg_a,
	output gb_core_pkg::byte_t reg_b,
	output gb_core_pkg::byte_t reg_c,
	output gb_core_pkg::byte_t reg_d,
	output gb_core_pkg::byte_t reg_e,
	output gb_core_pkg::byte_t reg_f,
	output gb_core_pkg::byte_t reg_h,
	output gb_core_pkg::byte_t reg_l
);
	ctrl_if ctrl_bus ();
	mem_if mem_bus ();
	logic [63:0] window;

	control_path control_path_i (.clk(clk), .rst(rst), .ctrl(ctrl_bus.ctrl), .halted(halted));

	datapath datapath_i (.clk(clk), .rst(rst), .ctrl(ctrl_bus.dp), .mem(mem_bus.cpu),
		.window(window));

	sram sram_i (.clk(clk), .mem(mem_bus.mem), .load_we(load_we), .load_addr(load_addr),
		.load_data(load_data));

	assign reg_a = window[7:0];
	assign reg_b = window[15:8];
	assign reg_c = window[23:16];
	assign reg_d = window[31:24];
	assign reg_e = window[39:32];
	assign reg_f = window[47:40];
	assign reg_h = window[55:48];
	assign reg_l = window[63:56];

endmodule

`default_nettype wire

// File: gb_core_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "gb_core_params.svh"

module gb_core_tb;
	import gb_core_pkg::*;

	// Register codes in opcode fields.
	localparam logic [2:0] R_B = 3'd0;
	localparam logic [2:0] R_C = 3'd1;
	localparam logic [2:0] R_D = 3'd2;
	localparam logic [2:0] R_E = 3'd3;
	localparam logic [2:0] R_H = 3'd4;
	localparam logic [2:0] R_L = 3'd5;
	localparam logic [2:0] R_A = 3'd7;

	// ALU field of opcodes 80-B7, plus INC outside that range.
	localparam logic [3:0] K_ADD = 4'd0;
	localparam logic [3:0] K_SUB = 4'd2;
	localparam logic [3:0] K_AND = 4'd4;
	localparam logic [3:0] K_XOR = 4'd5;
	localparam logic [3:0] K_OR = 4'd6;
	localparam logic [3:0] K_INC = 4'd8;

	localparam int HALT_TIMEOUT = 2000;

	logic clk, rst, load_we, halted;
	logic [`GB_ADDR_W-1:0] load_addr;
	byte_t load_data;
	byte_t reg_a, reg_b, reg_c, reg_d, reg_e, reg_f, reg_h, reg_l;

	byte_t prog_q [$];	// Program image from address 0.
	byte_t exp_r [0:7];	// Expected values by register code, F in slot 6.

	gb_core gb_core_i (
		.clk(clk),
		.rst(rst),
		.load_we(load_we),
		.load_addr(load_addr),
		.load_data(load_data),
		.halted(halted),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.reg_c(reg_c),
		.reg_d(reg_d),
		.reg_e(reg_e),
		.reg_f(reg_f),
		.reg_h(reg_h),
		.reg_l(reg_l)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Opcode builders and flag reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic byte_t op_ld_imm(input logic [2:0] r);
		return {2'b00, r, 3'b110};
	endfunction

	function automatic byte_t op_ld_rr(input logic [2:0] dst, input logic [2:0] src);
		return {2'b01, dst, src};
	endfunction

	function automatic byte_t op_alu(input logic [3:0] kind, input logic [2:0] src);
		return {2'b10, kind[2:0], src};
	endfunction

	function automatic byte_t op_inc(input logic [2:0] r);
		return {2'b00, r, 3'b100};
	endfunction

	// Returns {F, result}. F holds Z N H C in its upper nibble.
	function automatic logic [15:0] model_alu(input logic [3:0] kind, input byte_t a,
		input byte_t b, input byte_t f_prev);
		byte_t r;
		logic z, n, h, c;
		r = a;
		n = 1'b0;
		h = f_prev[5];
		c = f_prev[4];
		case (kind)
			K_ADD: begin
				r = a + b;
				h = ({4'h0, a[3:0]} + {4'h0, b[3:0]}) > 8'h0F;
				c = ({1'b0, a} + {1'b0, b}) > 9'h0FF;
			end
			K_SUB: begin
				r = a - b;
				n = 1'b1;
				h = a[3:0] < b[3:0];	// Borrow from bit 4.
				c = a < b;
			end
			K_AND: begin
				r = a & b;
				h = 1'b1;
				c = 1'b0;
			end
			K_OR, K_XOR: begin
				r = (kind == K_OR) ? (a | b) : (a ^ b);
				h = 1'b0;
				c = 1'b0;
			end
			K_INC: begin
				r = a + 8'd1;
				h = a[3:0] == 4'hF;	// Carry kept.
			end
			default: r = a;
		endcase
		z = r == 8'h00;
		return {z, n, h, c, 4'h0, r};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checking, loading and running
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic stop_with_failure();
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_reg(input string name, input byte_t got, input byte_t exp);
		assert (got === exp) else begin
			$display("[ERROR] t=%0t %s: got %02h, expected %02h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_regs();
		check_reg("reg_b", reg_b, exp_r[0]);
		check_reg("reg_c", reg_c, exp_r[1]);
		check_reg("reg_d", reg_d, exp_r[2]);
		check_reg("reg_e", reg_e, exp_r[3]);
		check_reg("reg_h", reg_h, exp_r[4]);
		check_reg("reg_l", reg_l, exp_r[5]);
		check_reg("reg_f", reg_f, exp_r[6]);
		check_reg("reg_a", reg_a, exp_r[7]);
	endtask

	task automatic start_test();
		@(negedge clk);
		rst = 1'b1;
		prog_q.delete();
		for (int i = 0; i < 8; i++)
			exp_r[i] = 8'h00;
	endtask

	task automatic emit(input byte_t b);
		prog_q.push_back(b);
	endtask

	task automatic write_mem(input logic [15:0] addr, input byte_t data);
		@(negedge clk);
		load_we = 1'b1;
		load_addr = addr[`GB_ADDR_W-1:0];
		load_data = data;
	endtask

	task automatic load_program();
		for (int i = 0; i < prog_q.size(); i++)
			write_mem(16'(i), prog_q[i]);
		@(negedge clk);
		load_we = 1'b0;
	endtask

	task automatic release_reset();
		repeat (3) @(negedge clk);
		assert (halted === 1'b0) else begin
			$display("halted is not low while reset is held");
			stop_with_failure();
		end
		rst = 1'b0;
	endtask

	task automatic run_to_halt();
		int cycles;
		cycles = 0;
		while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			$display("Timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
			stop_with_failure();
		end
	endtask

	task automatic run_and_check();
		load_program();
		release_reset();
		run_to_halt();
		check_regs();
	endtask

	// LD A,a then LD src,b then one ALU op on A.
	task automatic run_alu_case(input logic [3:0] kind, input logic [2:0] src,
		input byte_t a, input byte_t b);
		logic [15:0] res;
		byte_t b_eff;
		b_eff = (src == R_A) ? a : b;
		res = model_alu(kind, a, b_eff, 8'h00);
		start_test();
		emit(op_ld_imm(R_A));
		emit(a);
		if (src != R_A) begin
			emit(op_ld_imm(src));
			emit(b);
			exp_r[src] = b;
		end
		emit(op_alu(kind, src));
		emit(`GB_OP_HALT);
		exp_r[7] = res[7:0];
		exp_r[6] = res[15:8];
		run_and_check();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic test_ld_imm();
		byte_t vals [0:7];
		vals = '{8'h12, 8'h34, 8'h56, 8'h78, 8'h9A, 8'hBC, 8'h00, 8'hDE};
		$display("Test: LD r,d8");
		start_test();
		emit(8'h00);	// NOP.
		for (int r = 0; r < 8; r++) begin
			if (r != 6) begin
				emit(op_ld_imm(3'(r)));
				emit(vals[r]);
				exp_r[r] = vals[r];
			end
		end
		emit(`GB_OP_HALT);
		run_and_check();
	endtask

	task automatic test_alu_ops();
		$display("Test: ALU operations");
		run_alu_case(K_ADD, R_B, 8'h08, 8'h08);	// Half carry.
		run_alu_case(K_ADD, R_B, 8'hF0, 8'h10);	// Zero with carry.
		run_alu_case(K_ADD, R_C, 8'h3A, 8'hC6);
		run_alu_case(K_ADD, R_A, 8'h88, 8'h00);
		run_alu_case(K_SUB, R_B, 8'h10, 8'h01);	// Half borrow.
		run_alu_case(K_SUB, R_D, 8'h42, 8'h42);
		run_alu_case(K_SUB, R_B, 8'h01, 8'h02);	// Full borrow.
		run_alu_case(K_AND, R_E, 8'hF0, 8'h0F);
		run_alu_case(K_AND, R_B, 8'h3C, 8'h0F);
		run_alu_case(K_OR, R_H, 8'h00, 8'h00);
		run_alu_case(K_OR, R_B, 8'h50, 8'h05);
		run_alu_case(K_XOR, R_L, 8'h5A, 8'h5A);
		run_alu_case(K_XOR, R_B, 8'h5A, 8'hA5);
	endtask

	task automatic test_ld_rr_inc();
		logic [15:0] after_add, after_inc;
		$display("Test: LD r,r' and INC r");
		after_add = model_alu(K_ADD, 8'hF0, 8'h10, 8'h00);
		after_inc = model_alu(K_INC, 8'hFF, 8'h00, after_add[15:8]);
		start_test();
		emit(op_ld_imm(R_B));
		emit(8'hFF);
		emit(op_ld_imm(R_A));
		emit(8'hF0);
		emit(op_ld_imm(R_C));
		emit(8'h10);
		emit(op_alu(K_ADD, R_C));	// Sets C before the INC.
		emit(op_ld_rr(R_D, R_B));
		emit(op_ld_rr(R_E, R_D));
		emit(op_ld_rr(R_H, R_E));
		emit(op_ld_rr(R_L, R_H));
		emit(op_ld_rr(R_A, R_C));
		emit(op_inc(R_E));
		emit(`GB_OP_HALT);
		exp_r = '{8'hFF, 8'h10, 8'hFF, after_inc[7:0], 8'hFF, 8'hFF, after_inc[15:8], 8'h10};
		run_and_check();
	endtask

	task automatic test_hl_memory();
		logic [15:0] cleared;
		$display("Test: LD (HL),A and LD A,(HL)");
		cleared = model_alu(K_XOR, 8'h5E, 8'h5E, 8'h00);
		start_test();
		write_mem(16'h0200, 8'hA5);	// Stale byte, overwritten by the store.
		write_mem(16'h0201, 8'h3C);
		emit(op_ld_imm(R_H));
		emit(8'h02);
		emit(op_ld_imm(R_L));
		emit(8'h00);
		emit(op_ld_imm(R_A));
		emit(8'h5E);
		emit(8'h77);
		emit(op_alu(K_XOR, R_A));	// Clears A.
		emit(8'h7E);
		emit(op_ld_rr(R_B, R_A));
		emit(op_ld_imm(R_L));
		emit(8'h01);
		emit(8'h7E);
		emit(`GB_OP_HALT);
		exp_r = '{8'h5E, 8'h00, 8'h00, 8'h00, 8'h02, 8'h01, cleared[15:8], 8'h3C};
		run_and_check();
	endtask

	task automatic test_jp_loop();
		logic [15:0] res;
		byte_t count, loop_addr;
		$display("Test: JP and JP NZ loop");
		start_test();
		count = 8'h05;
		exp_r[7] = count;
		for (int guard = 0; guard < 256; guard++) begin
			res = model_alu(K_INC, exp_r[2], 8'h00, exp_r[6]);
			exp_r[2] = res[7:0];
			res = model_alu(K_SUB, exp_r[7], 8'h01, res[15:8]);
			exp_r[7] = res[7:0];
			exp_r[6] = res[15:8];
			if (res[15])
				break;
		end
		emit(8'hC3);	// JP 0005 over LD B,EE.
		emit(8'h05);
		emit(8'h00);
		emit(op_ld_imm(R_B));
		emit(8'hEE);
		emit(op_ld_imm(R_A));
		emit(count);
		emit(op_ld_imm(R_C));
		emit(8'h01);
		emit(op_ld_imm(R_D));
		emit(8'h00);
		loop_addr = 8'(prog_q.size());
		emit(op_inc(R_D));
		emit(op_alu(K_SUB, R_C));
		emit(8'hC2);
		emit(loop_addr);
		emit(8'h00);
		emit(`GB_OP_HALT);
		exp_r[1] = 8'h01;
		run_and_check();
	endtask

	task automatic test_random_add_sub();
		byte_t a, b;
		$display("Test: random ADD and SUB");
		for (int i = 0; i < 20; i++) begin
			a = 8'($urandom);
			b = 8'($urandom);
			run_alu_case(K_ADD, R_B, a, b);
			run_alu_case(K_SUB, R_C, a, b);
		end
	endtask

	initial begin
		void'($urandom(32'h6bdc17bc));
		rst = 1'b1;
		load_we = 1'b0;
		load_addr = '0;
		load_data = 8'h00;
		repeat (3) @(negedge clk);
		for (int i = 0; i < 8; i++)
			exp_r[i] = 8'h00;
		check_regs();	// All registers clear in reset.
		test_ld_imm();
		test_alu_ops();
		test_ld_rr_inc();
		test_hl_memory();
		test_jp_loop();
		test_random_add_sub();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: gb_core.f
+incdir+.
gb_core_pkg.sv
gb_core_ifs.sv
register_file.sv
alu.sv
control_path.sv
datapath.sv
sram.sv
gb_core.sv
gb_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the gb_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
verilator --binary --assert --timescale 1ns/100ps --top-module gb_core_tb \
	-f gb_core.f -o sim_gb_core > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_gb_core > "$LOG" 2>&1
cat "$LOG"
grep -q "=== FAIL ===" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" "$LOG" || { echo "Simulation ended without passing"; exit 1; }
exit 0
